// File: wb_pkg.sv
package wb_pkg;

	// ------------------------------
	// bus widths
	// ------------------------------

	// word address, one register per word
	localparam int wb_adr_width = 4;
	localparam int wb_dat_width = 32;

	// ------------------------------
	// bus signal bundles
	// ------------------------------

	// master to slave, classic cycle only
	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic                    we;
		logic [wb_adr_width-1:0] adr;
		logic [wb_dat_width-1:0] dat_w;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic                    ack;
		logic                    err;
		logic [wb_dat_width-1:0] dat_r;
	} wb_rsp_t;

	// ------------------------------
	// register map
	// ------------------------------

	// value of each mapped entry is its word address
	typedef enum logic [1:0] {
		reg_data   = 2'd0,
		reg_status = 2'd1,
		reg_none   = 2'd3
	} reg_sel_e;

endpackage

// File: fifo_pkg.sv
package fifo_pkg;

	// ------------------------------
	// sizes
	// ------------------------------

	localparam int fifo_data_width = 32;
	localparam int fifo_ptr_width  = 4;
	localparam int fifo_depth      = 1 << fifo_ptr_width;

	// one extra bit tells full from empty
	typedef logic [fifo_ptr_width:0] fifo_cnt_t;

	// output side word with its valid flag
	typedef struct packed {
		logic                       valid;
		logic [fifo_data_width-1:0] data;
	} stream_t;

	// ------------------------------
	// gray code helpers
	// ------------------------------

	function automatic fifo_cnt_t to_gray(input fifo_cnt_t bin);
		return bin ^ (bin >> 1);
	endfunction

	// msb passes through, each lower bit folds in the bits above it
	function automatic fifo_cnt_t from_gray(input fifo_cnt_t gray);
		fifo_cnt_t bin;
		bin[fifo_ptr_width] = gray[fifo_ptr_width];
		for (int i = fifo_ptr_width - 1; i >= 0; i--) begin
			bin[i] = bin[i + 1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

// File: ram_dualport.sv
`timescale 1ns/1ps

module ram_dualport #(
	parameter int data_width = 32,
	parameter int addr_width = 4
) (
	// write port
	input  logic                  in_clk,
	input  logic                  wr_en,
	input  logic [addr_width-1:0] wr_addr,
	input  logic [data_width-1:0] wr_data,

	// read port
	input  logic                  out_clk,
	input  logic [addr_width-1:0] rd_addr,
	output logic [data_width-1:0] rd_data
);

	localparam int depth = 1 << addr_width;

	logic [data_width-1:0] mem [depth];

	// ------------------------------
	// write side, in_clk
	// ------------------------------

	always_ff @(posedge in_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ------------------------------
	// read side, out_clk
	// ------------------------------

	// read every cycle, data lands one clock after the address
	always_ff @(posedge out_clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: gray_ptr_sync.sv
`timescale 1ns/1ps

module gray_ptr_sync #(
	parameter int width = fifo_pkg::fifo_ptr_width + 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [width-1:0] gray_in,
	output logic [width-1:0] binary_out
);
	import fifo_pkg::*;

	// first stage may go metastable, second one settles it
	logic [width-1:0] sync_q1;
	logic [width-1:0] sync_q2;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= gray_in;
			sync_q2 <= sync_q1;
		end
	end

	// decode registered so the compare logic downstream sees a clean value
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			binary_out <= '0;
		end else begin
			binary_out <= width'(from_gray(fifo_cnt_t'(sync_q2)));
		end
	end

endmodule

// File: fifo_fwft_async.sv
`timescale 1ns/1ps

module fifo_fwft_async (
	input  logic                                 reset,

	// write domain
	input  logic                                 in_clk,
	input  logic                                 push,
	input  logic [fifo_pkg::fifo_data_width-1:0] push_data,
	output logic                                 push_ready,
	output fifo_pkg::fifo_cnt_t                  free_num,

	// read domain
	input  logic                                 out_clk,
	output fifo_pkg::stream_t                    out_stream,
	input  logic                                 out_ready,
	output fifo_pkg::fifo_cnt_t                  out_data_num
);
	import fifo_pkg::*;

	// write side state
	fifo_cnt_t wr_ptr;
	fifo_cnt_t wr_ptr_gray;
	fifo_cnt_t wr_rptr;
	logic      wr_en;
	logic      full;

	// read side state
	fifo_cnt_t rd_ptr;
	fifo_cnt_t rd_ptr_gray;
	fifo_cnt_t rd_wptr;
	logic      empty;
	logic      pop;

	// output stage
	logic [fifo_data_width-1:0] ram_rd_data;
	logic                       ram_valid;
	logic [fifo_data_width-1:0] skid_data;
	logic                       skid_valid;
	logic                       out_valid;

	ram_dualport #(
		.data_width (fifo_data_width),
		.addr_width (fifo_ptr_width)
	) ram0 (
		.in_clk  (in_clk),
		.wr_en   (wr_en),
		.wr_addr (wr_ptr[fifo_ptr_width-1:0]),
		.wr_data (push_data),
		.out_clk (out_clk),
		.rd_addr (rd_ptr[fifo_ptr_width-1:0]),
		.rd_data (ram_rd_data)
	);

	// read pointer into the write domain
	gray_ptr_sync #(
		.width ($bits(fifo_cnt_t))
	) rptr_sync0 (
		.clk        (in_clk),
		.reset      (reset),
		.gray_in    (rd_ptr_gray),
		.binary_out (wr_rptr)
	);

	// write pointer into the read domain
	gray_ptr_sync #(
		.width ($bits(fifo_cnt_t))
	) wptr_sync0 (
		.clk        (out_clk),
		.reset      (reset),
		.gray_in    (wr_ptr_gray),
		.binary_out (rd_wptr)
	);

	// ------------------------------
	// write side
	// ------------------------------

	always_ff @(posedge in_clk or posedge reset) begin
		if (reset) begin
			wr_ptr      <= '0;
			wr_ptr_gray <= '0;
		end else begin
			// gray copy launched from a flop, never from logic
			wr_ptr_gray <= to_gray(wr_ptr);
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// full when the wrap bits differ and the addresses match
	assign full = (wr_ptr[fifo_ptr_width] != wr_rptr[fifo_ptr_width]) &&
		(wr_ptr[fifo_ptr_width-1:0] == wr_rptr[fifo_ptr_width-1:0]);

	assign push_ready = !full;
	assign wr_en      = push && push_ready;
	assign free_num   = fifo_cnt_t'(fifo_depth) + wr_rptr - wr_ptr;

	// ------------------------------
	// read side
	// ------------------------------

	assign empty     = (rd_wptr == rd_ptr);
	assign out_valid = skid_valid || ram_valid;
	assign pop       = !empty && (out_ready || !out_valid);

	// ram_valid: ram output holds a word, either popped or pending at rd_ptr
	// skid_valid: stalled word parked while the ram moves on
	always_ff @(posedge out_clk or posedge reset) begin
		if (reset) begin
			rd_ptr      <= '0;
			rd_ptr_gray <= '0;
			ram_valid   <= 1'b0;
			skid_valid  <= 1'b0;
		end else begin
			rd_ptr_gray <= to_gray(rd_ptr);
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			ram_valid <= !empty;
			if (out_ready) begin
				skid_valid <= 1'b0;
			end else if (!skid_valid) begin
				skid_valid <= ram_valid;
			end
		end
	end

	// capture on the first stalled edge only
	always_ff @(posedge out_clk) begin
		if (!out_ready && !skid_valid) begin
			skid_data <= ram_rd_data;
		end
	end

	assign out_stream.valid = out_valid;
	assign out_stream.data  = skid_valid ? skid_data : ram_rd_data;
	assign out_data_num     = rd_wptr - rd_ptr;

endmodule

// File: wb_fifo_port.sv
`timescale 1ns/1ps

module wb_fifo_port (
	input  logic                                 in_clk,
	input  logic                                 reset,

	// bus side
	input  wb_pkg::wb_req_t                      wb_req,
	output wb_pkg::wb_rsp_t                      wb_rsp,

	// fifo write side
	output logic                                 push,
	output logic [fifo_pkg::fifo_data_width-1:0] push_data,
	input  logic                                 push_ready,
	input  fifo_pkg::fifo_cnt_t                  free_num
);
	import wb_pkg::*;

	reg_sel_e                reg_sel;
	logic                    req_valid;
	logic                    wr_data_req;
	logic                    rd_status;
	logic                    bad_access;
	logic                    ack_q;
	logic                    err_q;
	logic [wb_dat_width-1:0] dat_r_q;

	// ------------------------------
	// address decode
	// ------------------------------

	always_comb begin
		if (wb_req.adr == wb_adr_width'(reg_data)) begin
			reg_sel = reg_data;
		end else if (wb_req.adr == wb_adr_width'(reg_status)) begin
			reg_sel = reg_status;
		end else begin
			reg_sel = reg_none;
		end
	end

	// master still holds stb during the response cycle, ignore it then
	assign req_valid   = wb_req.cyc && wb_req.stb && !(ack_q || err_q);
	assign wr_data_req = req_valid && wb_req.we && (reg_sel == reg_data);
	assign rd_status   = req_valid && !wb_req.we && (reg_sel == reg_status);
	assign bad_access  = req_valid && !(wr_data_req || rd_status);

	// full fifo leaves the write pending, master sees wait states
	assign push      = wr_data_req && push_ready;
	assign push_data = wb_req.dat_w;

	// ------------------------------
	// response
	// ------------------------------

	always_ff @(posedge in_clk or posedge reset) begin
		if (reset) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= push || rd_status;
			err_q <= bad_access;
		end
	end

	// free count zero extended to the bus width
	always_ff @(posedge in_clk) begin
		if (rd_status) begin
			dat_r_q <= wb_dat_width'(free_num);
		end
	end

	assign wb_rsp.ack   = ack_q;
	assign wb_rsp.err   = err_q;
	assign wb_rsp.dat_r = dat_r_q;

endmodule

// File: wb_stream_bridge.sv
`timescale 1ns/1ps

module wb_stream_bridge (
	input  logic                in_clk,
	input  logic                out_clk,
	input  logic                reset,

	// bus side, in_clk
	input  wb_pkg::wb_req_t     wb_req,
	output wb_pkg::wb_rsp_t     wb_rsp,

	// stream side, out_clk
	output fifo_pkg::stream_t   out_stream,
	input  logic                out_ready,
	output fifo_pkg::fifo_cnt_t out_data_num
);
	import fifo_pkg::*;

	// port to fifo
	logic                       push;
	logic [fifo_data_width-1:0] push_data;
	logic                       push_ready;
	fifo_cnt_t                  free_num;

	wb_fifo_port port0 (
		.in_clk     (in_clk),
		.reset      (reset),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.push       (push),
		.push_data  (push_data),
		.push_ready (push_ready),
		.free_num   (free_num)
	);

	fifo_fwft_async fifo0 (
		.reset        (reset),
		.in_clk       (in_clk),
		.push         (push),
		.push_data    (push_data),
		.push_ready   (push_ready),
		.free_num     (free_num),
		.out_clk      (out_clk),
		.out_stream   (out_stream),
		.out_ready    (out_ready),
		.out_data_num (out_data_num)
	);

endmodule

// File: tb_wb_stream_bridge_assert.sv
`timescale 1ns/1ps

module tb_wb_stream_bridge_assert (
	input  logic                in_clk,
	input  logic                out_clk,
	input  logic                reset,
	input  wb_pkg::wb_req_t     wb_req,
	input  wb_pkg::wb_rsp_t     wb_rsp,
	input  fifo_pkg::stream_t   out_stream,
	input  logic                out_ready,
	input  fifo_pkg::fifo_cnt_t out_data_num
);
	import wb_pkg::*;
	import fifo_pkg::*;

	// the output stage can hold one popped word on top of the ram entries
	localparam int hold_max = fifo_depth + 1;

	logic [fifo_data_width-1:0] shadow_mem [256];
	logic [fifo_data_width-1:0] head_data;
	int                         wr_cnt;
	int                         rd_cnt;
	int                         shadow_count;
	int                         rd_hist [8];
	int                         status_hi;
	int                         status_lo;
	logic                       fresh_req;
	logic                       bad_req;
	logic                       data_ack;
	logic                       status_ack;
	logic                       error_seen;

	initial error_seen = 1'b0;

	// ------------------------------
	// shadow queue
	// ------------------------------

	assign data_ack   = wb_rsp.ack && wb_req.we && (wb_req.adr == wb_adr_width'(reg_data));
	assign status_ack = wb_rsp.ack && !wb_req.we &&
		(wb_req.adr == wb_adr_width'(reg_status));
	assign fresh_req  = wb_req.cyc && wb_req.stb && !wb_rsp.ack && !wb_rsp.err;
	assign bad_req    = fresh_req && !((wb_req.we && wb_req.adr == wb_adr_width'(reg_data)) ||
		(!wb_req.we && wb_req.adr == wb_adr_width'(reg_status)));

	always_ff @(posedge in_clk) begin
		if (data_ack) begin
			shadow_mem[wr_cnt[7:0]] <= wb_req.dat_w;
		end
	end

	always_ff @(posedge in_clk or posedge reset) begin
		if (reset) begin
			wr_cnt <= 0;
			for (int i = 0; i < 8; i++) begin
				rd_hist[i] <= 0;
			end
		end else begin
			if (data_ack) begin
				wr_cnt <= wr_cnt + 1;
			end
			// pop counts seen from the bus side, oldest at the end
			rd_hist[0] <= rd_cnt;
			for (int i = 1; i < 8; i++) begin
				rd_hist[i] <= rd_hist[i-1];
			end
		end
	end

	always_ff @(posedge out_clk or posedge reset) begin
		if (reset) begin
			rd_cnt <= 0;
		end else if (out_stream.valid && out_ready) begin
			rd_cnt <= rd_cnt + 1;
		end
	end

	assign shadow_count = wr_cnt - rd_cnt;
	assign head_data    = shadow_mem[rd_cnt[7:0]];
	assign status_hi    = hold_max - shadow_count;
	assign status_lo    = fifo_depth - wr_cnt + rd_hist[7];

	// ------------------------------
	// checks
	// ------------------------------

	a_order: assert property (@(posedge out_clk) disable iff (reset)
		(out_stream.valid && out_ready) |-> (shadow_count > 0 && out_stream.data == head_data))
	else begin
		$error("CHECK FAILED out_stream.data=%h expected %h", out_stream.data, head_data);
		error_seen = 1'b1;
	end

	a_stable: assert property (@(posedge out_clk) disable iff (reset)
		(out_stream.valid && !out_ready) |=> (out_stream.valid && $stable(out_stream.data)))
	else begin
		$error("stream word changed or dropped while the sink stalled");
		error_seen = 1'b1;
	end

	a_depth: assert property (@(posedge in_clk) disable iff (reset)
		data_ack |-> (shadow_count < hold_max))
	else begin
		$error("CHECK FAILED shadow_count=%h at ack, limit %h", shadow_count, hold_max);
		error_seen = 1'b1;
	end

	a_status: assert property (@(posedge in_clk) disable iff (reset)
		status_ack |-> (int'(wb_rsp.dat_r) <= status_hi && int'(wb_rsp.dat_r) >= status_lo))
	else begin
		$error("CHECK FAILED wb_rsp.dat_r=%h expected %h..%h", wb_rsp.dat_r, status_lo, status_hi);
		error_seen = 1'b1;
	end

	a_err_resp: assert property (@(posedge in_clk) disable iff (reset)
		bad_req |=> (wb_rsp.err && !wb_rsp.ack))
	else begin
		$error("unmapped or wrong-direction access did not end with err alone");
		error_seen = 1'b1;
	end

	a_reset_state: assert property (@(posedge in_clk)
		(reset || $fell(reset)) |->
		(!wb_rsp.ack && !wb_rsp.err && !out_stream.valid && out_data_num == '0))
	else begin
		$error("outputs not idle around reset");
		error_seen = 1'b1;
	end

endmodule

bind wb_stream_bridge tb_wb_stream_bridge_assert chk0 (
	.in_clk       (in_clk),
	.out_clk      (out_clk),
	.reset        (reset),
	.wb_req       (wb_req),
	.wb_rsp       (wb_rsp),
	.out_stream   (out_stream),
	.out_ready    (out_ready),
	.out_data_num (out_data_num)
);

// File: tb_wb_stream_bridge.sv
`timescale 1ns/1ps

module tb_wb_stream_bridge;
	import wb_pkg::*;
	import fifo_pkg::*;

	localparam int num_random = 40;
	localparam int num_stall  = 24;
	localparam int num_words  = num_random + num_stall;
	localparam realtime limit_ns = num_words * 40 * 26.0 + 2000.0;

	logic        in_clk;
	logic        out_clk;
	logic        reset;
	logic        out_ready;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	stream_t     out_stream;
	fifo_cnt_t   out_data_num;
	logic [15:0] data_lfsr;
	logic [15:0] ready_lfsr;
	logic [31:0] ready_bits;
	logic [31:0] word;
	// 0 random, 1 stalled, 2 always ready
	logic [1:0]  sink_mode;

	wb_stream_bridge dut0 (
		.in_clk       (in_clk),
		.out_clk      (out_clk),
		.reset        (reset),
		.wb_req       (wb_req),
		.wb_rsp       (wb_rsp),
		.out_stream   (out_stream),
		.out_ready    (out_ready),
		.out_data_num (out_data_num)
	);

	initial begin
		in_clk = 1'b0;
		forever #10 in_clk = ~in_clk;
	end

	initial begin
		out_clk = 1'b0;
		forever #13 out_clk = ~out_clk;
	end

	// galois lfsr stepped once per bit
	task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits  = {bits[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
		end
	endtask

	// one classic cycle held until ack or err
	task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat);
		@(posedge in_clk);
		wb_req.cyc   <= 1'b1;
		wb_req.stb   <= 1'b1;
		wb_req.we    <= we;
		wb_req.adr   <= adr;
		wb_req.dat_w <= dat;
		@(posedge in_clk);
		while (!(wb_rsp.ack || wb_rsp.err)) begin
			@(posedge in_clk);
		end
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
	endtask

	// stream sink
	always @(posedge out_clk) begin
		if (sink_mode == 2'd0) begin
			draw_bits(ready_lfsr, 1, ready_bits);
			out_ready <= ready_bits[0];
		end else begin
			out_ready <= (sink_mode == 2'd2);
		end
	end

	always @(posedge in_clk) begin
		if (dut0.chk0.error_seen) begin
			$display("TEST FAIL");
			$fatal(1, "assertion failure in the bound checker");
		end
	end

	initial begin
		#(limit_ns);
		$display("TEST FAIL");
		$fatal(1, "watchdog timeout, bus or stream stopped making progress");
	end

	initial begin
		reset      = 1'b1;
		out_ready  = 1'b0;
		sink_mode  = 2'd2;
		wb_req     = '0;
		data_lfsr  = 16'd97;
		ready_lfsr = 16'd97;
		repeat (10) @(posedge in_clk);
		reset <= 1'b0;

		// error responses, then a status read on an empty fifo
		bus_access(1'b0, 4'd0, 32'h0);
		bus_access(1'b1, 4'd1, 32'h1234);
		bus_access(1'b0, 4'd5, 32'h0);
		bus_access(1'b0, 4'd1, 32'h0);

		// random words against a random sink
		sink_mode <= 2'd0;
		for (int i = 0; i < num_random; i++) begin
			draw_bits(data_lfsr, 32, word);
			bus_access(1'b1, 4'd0, word);
			if (i % 8 == 7) begin
				bus_access(1'b0, 4'd1, 32'h0);
			end
		end

		// sink stalled until well after the fifo fills
		sink_mode <= 2'd1;
		fork
			begin
				for (int i = 0; i < num_stall; i++) begin
					draw_bits(data_lfsr, 32, word);
					bus_access(1'b1, 4'd0, word);
				end
			end
			begin
				repeat (100) @(posedge in_clk);
				sink_mode <= 2'd2;
			end
		join

		while (dut0.chk0.shadow_count != 0) begin
			@(posedge in_clk);
		end
		bus_access(1'b0, 4'd1, 32'h0);
		repeat (4) @(posedge in_clk);

		if (dut0.chk0.error_seen) begin
			$display("TEST FAIL");
			$fatal(1, "assertion failure in the bound checker");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: vlog.f
wb_pkg.sv
fifo_pkg.sv
ram_dualport.sv
gray_ptr_sync.sv
fifo_fwft_async.sv
wb_fifo_port.sv
wb_stream_bridge.sv
tb_wb_stream_bridge_assert.sv
tb_wb_stream_bridge.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_wb_stream_bridge -f vlog.f -o sim_wb_stream_bridge

if ! ./obj_dir/sim_wb_stream_bridge > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
